/* testbench/uartPatterns.txt */
// columns: cmd_addr/count_data  cmd 01 write, 02 read check, 03 send, 04 external byte,
// 05 bad stop bit, 06 random external burst, 07 send with a second start while busy, 00 end
02_00_000a
02_02_0000
03_00_0055
03_00_00a3
07_00_003c
01_01_0001
03_00_00e7
04_00_0011
03_00_0018
01_01_0000
06_04_0000
05_00_0081
02_02_0001
01_02_0000
02_02_0000
01_00_0001
02_00_0002
03_00_005a
04_00_00c3
01_00_000c
03_00_0096
06_02_0000
00_00_0000

/* vlog.f */
source/uartFramePkg.sv
source/uartRegPkg.sv
source/uartTx.sv
source/uartRx.sv
source/uartRegs.sv
source/uartTop.sv
testbench/uartChecker.sv
testbench/uartTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= uartTb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TEST PASS" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* testbench/uartTb.sv */
`timescale 1ns/1ps

module uartTb;
    import uartRegPkg::*;

    localparam int waitLimit = 50000;                 // cycles allowed for any single wait

    logic        clk;
    logic        rstN;
    logic        start;
    logic        rxd;
    logic        cfgWrite;
    logic        ready;
    logic        txd;
    logic        rxValid;
    logic [7:0]  txByte;
    logic [7:0]  rxByte;
    logic [7:0]  pushByte;
    logic [7:0]  randByte;
    logic        pushTx;
    logic        pushRx;
    logic        checkRead;
    regAddrE     cfgAddr;
    logic [15:0] cfgWdata;
    logic [15:0] cfgRdata;
    logic [15:0] readExpect;
    logic [15:0] divCopy;                             // the bench's own idea of the divisor
    logic        loopCopy;
    logic [31:0] lfsr;
    logic [31:0] patterns [0:63];
    logic [31:0] p;
    logic        done;
    int          errorCount;
    int          txPending;
    int          rxPending;
    int          timeouts;

    uartTop UUT (.*);

    uartChecker uChecker (
        .clk(clk), .rstN(rstN), .txd(txd), .ready(ready), .start(start),
        .rxValid(rxValid), .pushTx(pushTx), .pushRx(pushRx), .checkRead(checkRead),
        .rxByte(rxByte), .pushByte(pushByte), .cfgRdata(cfgRdata),
        .readExpect(readExpect), .divisor(divCopy), .errorCount(errorCount),
        .txPending(txPending), .rxPending(rxPending)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ##########################################################
    // stimulus helpers
    // ##########################################################

    // galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic nextRandByte(output logic [7:0] b);
        for (int i = 0; i < 8; i++) begin
            b[i] = lfsr[0];                           // one step per bit taken
            lfsr = lfsrStep(lfsr);
        end
    endtask

    task automatic waitReady();
        int n;
        n = 0;
        while (!ready && n < waitLimit) begin
            @(negedge clk);
            n++;
        end
        if (!ready) begin
            $display("timed out at %0t waiting for the transmitter to become ready", $time);
            timeouts++;
        end
    endtask

    task automatic writeReg(input regAddrE addr, input logic [15:0] data);
        waitReady();
        if (addr == regControl && !data[ctrlLoopbackBit]) rxd = 1'b1;  // idle line before handover
        cfgWrite = 1'b1;
        cfgAddr  = addr;
        cfgWdata = data;
        @(negedge clk);
        cfgWrite = 1'b0;
        if (addr == regDivisor) divCopy = (data < 16'd2) ? 16'd2 : data;
        if (addr == regControl) begin
            loopCopy = data[ctrlLoopbackBit];
            if (loopCopy) rxd = 1'b0;                 // external line should now be ignored
        end
    endtask

    task automatic readCheck(input regAddrE addr, input logic [15:0] expected);
        cfgAddr    = addr;
        readExpect = expected;
        checkRead  = 1'b1;
        @(negedge clk);
        checkRead  = 1'b0;
    endtask

    task automatic sendByte(input logic [7:0] b, input logic busyPulse);
        waitReady();
        start    = 1'b1;
        txByte   = b;
        pushTx   = 1'b1;
        pushRx   = loopCopy;
        pushByte = b;
        @(negedge clk);
        start  = 1'b0;
        pushTx = 1'b0;
        pushRx = 1'b0;
        if (busyPulse) begin
            repeat (3) @(negedge clk);
            start  = 1'b1;                            // must be dropped, the frame is running
            txByte = ~b;
            @(negedge clk);
            start  = 1'b0;
        end
    endtask

    // serial line model for the external receive path
    task automatic driveSerial(input logic [7:0] b, input logic stopLevel, input logic expectRx);
        pushRx   = expectRx && !loopCopy;
        pushByte = b;
        for (int k = 0; k < 10; k++) begin
            rxd = (k == 0) ? 1'b0 : (k == 9) ? stopLevel : b[k-1];
            @(negedge clk);
            pushRx = 1'b0;
            repeat (divCopy - 1) @(negedge clk);
        end
        rxd = 1'b1;
        repeat (divCopy) @(negedge clk);
    endtask

    // ##########################################################
    // pattern sequencing
    // ##########################################################

    initial begin
        int n;
        rstN = 1'b0;
        start = 1'b0;
        rxd = 1'b1;
        cfgWrite = 1'b0;
        cfgAddr = regDivisor;
        cfgWdata = '0;
        txByte = '0;
        pushTx = 1'b0;
        pushRx = 1'b0;
        pushByte = '0;
        checkRead = 1'b0;
        readExpect = '0;
        divCopy = 16'd10;
        loopCopy = 1'b0;
        lfsr = 32'he5f3;
        timeouts = 0;
        done = 1'b0;
        $readmemh("testbench/uartPatterns.txt", patterns);
        repeat (3) @(negedge clk);
        rstN = 1'b1;
        @(negedge clk);
        for (int i = 0; i < 64 && !done; i++) begin
            p = patterns[i];
            case (p[31:24])
                8'h01: writeReg(regAddrE'(p[17:16]), p[15:0]);
                8'h02: readCheck(regAddrE'(p[17:16]), p[15:0]);
                8'h03: sendByte(p[7:0], 1'b0);
                8'h04: driveSerial(p[7:0], 1'b1, 1'b1);
                8'h05: driveSerial(p[7:0], 1'b0, 1'b0);
                8'h06: begin
                    repeat (p[23:16]) begin
                        nextRandByte(randByte);
                        driveSerial(randByte, 1'b1, 1'b1);
                    end
                end
                8'h07: sendByte(p[7:0], 1'b1);
                default: done = 1'b1;                 // end marker or past the last line
            endcase
        end
        waitReady();
        n = 0;
        while ((txPending != 0 || rxPending != 0) && n < waitLimit) begin
            @(negedge clk);
            n++;
        end
        if (txPending != 0 || rxPending != 0) begin
            $display("timed out waiting for %0d transmit and %0d receive bytes to arrive",
                     txPending, rxPending);
            timeouts++;
        end
        $display("checker errors %0d, timeouts %0d", errorCount, timeouts);
        if (errorCount == 0 && timeouts == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* testbench/uartChecker.sv */
`timescale 1ns/1ps

module uartChecker (
    input  logic        clk,
    input  logic        rstN,
    input  logic        txd,
    input  logic        ready,
    input  logic        start,
    input  logic        rxValid,
    input  logic        pushTx,
    input  logic        pushRx,
    input  logic        checkRead,
    input  logic [7:0]  rxByte,
    input  logic [7:0]  pushByte,
    input  logic [15:0] cfgRdata,
    input  logic [15:0] readExpect,
    input  logic [15:0] divisor,
    output int          errorCount,
    output int          txPending,
    output int          rxPending
);
    logic [7:0] txQueue[$];
    logic [7:0] rxQueue[$];
    logic       txdPrev;
    logic       readyPrev;
    logic       decoding;
    logic       resetChecked;
    logic       timing;
    logic [7:0] shiftIn;
    int         cycle;
    int         acceptCycle;
    int         frameDiv;
    int         offset;
    int         bitNum;

    task automatic compare(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("** Error at %0t: %s expected %0h got %0h", $time, name, expected, actual);
            errorCount++;
        end
    endtask

    initial errorCount = 0;

    always @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            txdPrev = 1'b1;
            readyPrev = 1'b1;
            decoding = 1'b0;
            resetChecked = 1'b0;
            timing = 1'b0;
            cycle = 0;
        end else begin
            cycle++;
            if (!resetChecked) begin
                compare("txd", 1, txd);
                compare("ready", 1, ready);
                compare("rxValid", 0, rxValid);
                resetChecked = 1'b1;
            end
            if (pushTx) txQueue.push_back(pushByte);
            if (pushRx) rxQueue.push_back(pushByte);
            if (checkRead) compare("cfgRdata", readExpect, cfgRdata);
            if (ready && !readyPrev && timing) begin
                // ready rises 10*div+2 edges after accept, this edge is the first to see it
                compare("ready latency", 10 * frameDiv + 3, cycle - acceptCycle);
                timing = 1'b0;
            end
            if (start && ready) begin
                acceptCycle = cycle;
                frameDiv = divisor;                   // the frame keeps this divisor
                timing = 1'b1;
            end

            // independent decode of txd, sampled at mid-bit from the falling edge
            if (decoding) begin
                offset++;
                if (offset == frameDiv) begin
                    offset = 0;
                    bitNum++;
                end
            end else if (txdPrev && !txd) begin
                decoding = 1'b1;
                offset = 0;
                bitNum = 0;
            end
            if (decoding && offset == frameDiv / 2) begin
                if (bitNum == 0) begin
                    compare("txd start bit", 0, txd);
                end else if (bitNum < 9) begin
                    shiftIn = {txd, shiftIn[7:1]};
                end else begin
                    compare("txd stop bit", 1, txd);
                    decoding = 1'b0;
                    if (txQueue.size() == 0) begin
                        $display("a frame appeared on txd at %0t with no byte queued", $time);
                        errorCount++;
                    end else begin
                        compare("txd byte", txQueue.pop_front(), shiftIn);
                    end
                end
            end

            if (rxValid) begin
                if (rxQueue.size() == 0) begin
                    $display("rxValid pulsed at %0t although no byte was expected", $time);
                    errorCount++;
                end else begin
                    compare("rxByte", rxQueue.pop_front(), rxByte);
                end
            end
            txdPrev = txd;
            readyPrev = ready;
        end
        txPending = txQueue.size();
        rxPending = rxQueue.size();
    end

endmodule

/* source/uartTop.sv */
`timescale 1ns/1ps

module uartTop #(
    parameter int clkFreqMhz = 10,
    parameter int baudRate   = 1000000
) (
    input  logic                              clk,
    input  logic                              rstN,
    input  logic                              start,
    input  logic [uartFramePkg::dataBits-1:0] txByte,
    output logic                              ready,
    output logic                              txd,
    input  logic                              rxd,
    output logic [uartFramePkg::dataBits-1:0] rxByte,
    output logic                              rxValid,
    input  logic                              cfgWrite,
    input  uartRegPkg::regAddrE               cfgAddr,
    input  logic [uartRegPkg::regWidth-1:0]   cfgWdata,
    output logic [uartRegPkg::regWidth-1:0]   cfgRdata
);
    import uartFramePkg::*;

    logic [divWidth-1:0] divisor;
    logic                loopback;
    logic                frameError;
    logic                rxdSel;

    assign rxdSel = loopback ? txd : rxd;                     // external line is ignored in loopback

    uartRegs #(
        .clkFreqMhz (clkFreqMhz),
        .baudRate   (baudRate)
    ) uRegs (
        .clk        (clk),
        .rstN       (rstN),
        .cfgWrite   (cfgWrite),
        .cfgAddr    (cfgAddr),
        .cfgWdata   (cfgWdata),
        .cfgRdata   (cfgRdata),
        .frameError (frameError),
        .divisor    (divisor),
        .loopback   (loopback)
    );

    uartTx uTx (
        .clk     (clk),
        .rstN    (rstN),
        .start   (start),
        .data    (txByte),
        .divisor (divisor),
        .txd     (txd),
        .ready   (ready)
    );

    uartRx uRx (
        .clk        (clk),
        .rstN       (rstN),
        .rxd        (rxdSel),
        .divisor    (divisor),
        .rxByte     (rxByte),
        .rxValid    (rxValid),
        .frameError (frameError)
    );

endmodule

/* source/uartRegs.sv */
`timescale 1ns/1ps

module uartRegs #(
    parameter int clkFreqMhz = 10,
    parameter int baudRate   = 1000000
) (
    input  logic                              clk,
    input  logic                              rstN,
    input  logic                              cfgWrite,
    input  uartRegPkg::regAddrE               cfgAddr,
    input  logic [uartRegPkg::regWidth-1:0]   cfgWdata,
    output logic [uartRegPkg::regWidth-1:0]   cfgRdata,
    input  logic                              frameError,
    output logic [uartFramePkg::divWidth-1:0] divisor,
    output logic                              loopback
);
    import uartFramePkg::*;
    import uartRegPkg::*;

    // the receiver waits half a divisor, so anything under 2 is meaningless
    localparam logic [divWidth-1:0] divMin   = divWidth'(2);
    localparam int                  divRaw   = (clkFreqMhz * 1000000) / baudRate;
    localparam logic [divWidth-1:0] divReset = (divRaw < 2) ? divMin : divWidth'(divRaw);

    logic [regWidth-1:0] errCount;

    // ##########################################################
    // register writes
    // ##########################################################

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            divisor  <= divReset;
            loopback <= 1'b0;
            errCount <= '0;
        end else begin
            if (cfgWrite && cfgAddr == regDivisor) begin
                divisor <= (cfgWdata < regWidth'(divMin)) ? divMin : divWidth'(cfgWdata);
            end
            if (cfgWrite && cfgAddr == regControl) begin
                loopback <= cfgWdata[ctrlLoopbackBit];
            end
            if (cfgWrite && cfgAddr == regErrCount) begin
                errCount <= '0;                               // the written value is ignored
            end else if (frameError && errCount != '1) begin
                errCount <= errCount + 1'b1;                  // sticks at all ones
            end
        end
    end

    // ##########################################################
    // read mux
    // ##########################################################

    always_comb begin
        cfgRdata = '0;
        case (cfgAddr)
            regDivisor:  cfgRdata = regWidth'(divisor);
            regControl:  cfgRdata[ctrlLoopbackBit] = loopback;
            regErrCount: cfgRdata = errCount;
            default:     cfgRdata = '0;
        endcase
    end

    divisorFloor: assert property (
        @(posedge clk) disable iff (!rstN) divisor >= divMin
    );

endmodule

/* source/uartRx.sv */
`timescale 1ns/1ps

module uartRx (
    input  logic                              clk,
    input  logic                              rstN,
    input  logic                              rxd,
    input  logic [uartFramePkg::divWidth-1:0] divisor,
    output logic [uartFramePkg::dataBits-1:0] rxByte,
    output logic                              rxValid,
    output logic                              frameError
);
    import uartFramePkg::*;

    logic                   rxdMeta;
    logic                   rxdSync;
    rxStateE                state;
    logic [divWidth-1:0]    cycleCnt;
    logic [divWidth-1:0]    divLatched;
    logic [bitIdxWidth-1:0] bitIdx;
    logic [dataBits-1:0]    shiftData;
    logic                   startSeen;
    logic                   halfDone;
    logic                   bitDone;

    // ##########################################################
    // input synchronizer
    // ##########################################################

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rxdMeta <= 1'b1;                                  // idle line is high
            rxdSync <= 1'b1;
        end else begin
            rxdMeta <= rxd;
            rxdSync <= rxdMeta;
        end
    end

    // ##########################################################
    // receive sequencing
    // ##########################################################

    assign startSeen = (state == rxIdle) && !rxdSync;
    assign halfDone  = (cycleCnt == (divLatched >> 1) - 1'b1);
    assign bitDone   = (cycleCnt == divLatched - 1'b1);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state      <= rxIdle;
            cycleCnt   <= '0;
            bitIdx     <= '0;
            rxValid    <= 1'b0;
            frameError <= 1'b0;
        end else begin
            rxValid    <= 1'b0;
            frameError <= 1'b0;
            case (state)
                rxIdle: begin
                    if (startSeen) begin
                        state    <= rxStartBit;
                        cycleCnt <= '0;
                    end
                end
                rxStartBit: begin
                    if (halfDone) begin
                        cycleCnt <= '0;
                        if (rxdSync) begin
                            state <= rxIdle;                  // glitch, not a real start bit
                        end else begin
                            state  <= rxDataBit;
                            bitIdx <= '0;
                        end
                    end else begin
                        cycleCnt <= cycleCnt + 1'b1;
                    end
                end
                rxDataBit: begin
                    if (bitDone) begin
                        cycleCnt <= '0;
                        if (bitIdx == bitIdxWidth'(dataBits - 1)) begin
                            state <= rxStopBit;
                        end else begin
                            bitIdx <= bitIdx + 1'b1;
                        end
                    end else begin
                        cycleCnt <= cycleCnt + 1'b1;
                    end
                end
                rxStopBit: begin
                    if (bitDone) begin
                        state      <= rxIdle;
                        rxValid    <= rxdSync;
                        frameError <= !rxdSync;
                    end else begin
                        cycleCnt <= cycleCnt + 1'b1;
                    end
                end
                default: state <= rxIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (startSeen) begin
            divLatched <= divisor;
        end
        if (state == rxDataBit && bitDone) begin
            shiftData <= {rxdSync, shiftData[dataBits-1:1]};  // lsb arrives first
        end
        if (state == rxStopBit && bitDone && rxdSync) begin
            rxByte <= shiftData;                             // held until the next good frame
        end
    end

    oneOutcomePerFrame: assert property (
        @(posedge clk) disable iff (!rstN) !(rxValid && frameError)
    );

endmodule

/* source/uartTx.sv */
`timescale 1ns/1ps

module uartTx (
    input  logic                              clk,
    input  logic                              rstN,
    input  logic                              start,
    input  logic [uartFramePkg::dataBits-1:0] data,
    input  logic [uartFramePkg::divWidth-1:0] divisor,
    output logic                              txd,
    output logic                              ready
);
    import uartFramePkg::*;

    txStateE                state;
    logic [divWidth-1:0]    cycleCnt;
    logic [divWidth-1:0]    divLatched;
    logic [bitIdxWidth-1:0] bitIdx;
    logic [dataBits-1:0]    shiftData;
    logic                   accept;
    logic                   bitDone;

    assign accept  = start && ready;                  // a start while busy is dropped
    assign bitDone = (cycleCnt == divLatched - 1'b1);

    // ##########################################################
    // frame sequencing
    // ##########################################################

    // txd is registered from the state, so the line trails the state by one cycle
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state    <= txIdle;
            ready    <= 1'b1;
            txd      <= 1'b1;
            cycleCnt <= '0;
            bitIdx   <= '0;
        end else begin
            case (state)
                txIdle: begin
                    if (accept) begin
                        state    <= txStartBit;
                        ready    <= 1'b0;
                        cycleCnt <= '0;
                    end
                end
                txStartBit: begin
                    txd <= 1'b0;
                    if (bitDone) begin
                        state    <= txDataBit;
                        bitIdx   <= '0;
                        cycleCnt <= '0;
                    end else begin
                        cycleCnt <= cycleCnt + 1'b1;
                    end
                end
                txDataBit: begin
                    txd <= shiftData[0];
                    if (bitDone) begin
                        cycleCnt <= '0;
                        if (bitIdx == bitIdxWidth'(dataBits - 1)) begin
                            state <= txStopBit;
                        end else begin
                            bitIdx <= bitIdx + 1'b1;
                        end
                    end else begin
                        cycleCnt <= cycleCnt + 1'b1;
                    end
                end
                txStopBit: begin
                    txd <= 1'b1;
                    if (bitDone) begin
                        state    <= txSettle;
                        cycleCnt <= '0;
                    end else begin
                        cycleCnt <= cycleCnt + 1'b1;
                    end
                end
                txSettle: begin
                    if (cycleCnt != '0) begin                 // first cycle ends the stop bit on the line
                        state <= txIdle;
                        ready <= 1'b1;
                    end else begin
                        cycleCnt <= cycleCnt + 1'b1;
                    end
                end
                default: state <= txIdle;
            endcase
        end
    end

    // byte and divisor are frozen for the whole frame
    always_ff @(posedge clk) begin
        if (accept) begin
            shiftData  <= data;
            divLatched <= divisor;
        end else if (state == txDataBit && bitDone) begin
            shiftData <= shiftData >> 1;                     // lsb goes out first
        end
    end

    readyOnlyInIdle: assert property (
        @(posedge clk) disable iff (!rstN) (state != txIdle) |-> !ready
    );

    lineIdleHigh: assert property (
        @(posedge clk) disable iff (!rstN) (state == txIdle) |-> txd
    );

endmodule

/* source/uartRegPkg.sv */
package uartRegPkg;

    // ##########################################################
    // register map
    // ##########################################################

    typedef enum logic [1:0] {
        regDivisor  = 2'd0,                           // clock cycles per serial bit
        regControl  = 2'd1,
        regErrCount = 2'd2                            // any write clears it
    } regAddrE;

    localparam int regWidth = 16;

    // ##########################################################
    // control register fields
    // ##########################################################

    localparam int ctrlLoopbackBit = 0;               // receiver listens to our own txd

endpackage

/* source/uartFramePkg.sv */
package uartFramePkg;

    // ##########################################################
    // frame geometry
    // ##########################################################

    localparam int dataBits    = 8;                   // 8N1, one byte per frame
    localparam int bitIdxWidth = $clog2(dataBits);    // enough to count the data bits

    // ##########################################################
    // bit timing
    // ##########################################################

    localparam int divWidth = 16;                     // clock cycles per bit, set at runtime

    // ##########################################################
    // state machines
    // ##########################################################

    typedef enum logic [2:0] {
        txIdle,
        txStartBit,
        txDataBit,
        txStopBit,
        txSettle                                      // one quiet cycle before ready returns
    } txStateE;

    typedef enum logic [1:0] {
        rxIdle,
        rxStartBit,                                   // waits half a bit to find the middle
        rxDataBit,
        rxStopBit
    } rxStateE;

endpackage
